/* xvid_pkg.sv */
`default_nettype none

package xvid_pkg;

    localparam int WORD_W          = 16;               // vram and register word
    localparam int VRAM_AW         = 12;               // vram word address bits
    localparam int VRAM_WORDS      = 1 << VRAM_AW;     // 4096 words
    localparam int PIX_PER_WORD    = 4;                // 4-bit pixels per word
    localparam int VRAM_RD_LATENCY = 1;                // registered read port

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [VRAM_AW-1:0] vram_addr_t;
    typedef logic [11:0]        rgb_t;                 // {r, g, b} nibbles
    typedef logic [3:0]         color_t;               // palette index
    typedef logic [1:0]         intr_t;                // one bit per source

    // host visible register numbers
    typedef enum logic [3:0] {
        REG_WR_ADDR   = 4'h0,
        REG_RD_ADDR   = 4'h1,
        REG_DATA      = 4'h2,
        REG_XR_ADDR   = 4'h3,
        REG_XR_DATA   = 4'h4,
        REG_INT_CTRL  = 4'h5,
        REG_LINE_INTR = 4'h6
    } reg_num_t;

    // bit positions in intr_t
    typedef enum logic [0:0] {
        INTR_VBLANK = 1'b0,
        INTR_LINE   = 1'b1
    } intr_src_e;

endpackage

`default_nettype wire

/* vram_bus_if.sv */
`default_nettype none
`timescale 1ns/1ps

// register unit to arbiter, sel held until ack
interface vram_bus_if;
    import xvid_pkg::*;

    logic       sel;        // request pending
    logic       wr;         // 1 = write, 0 = prefetch read
    vram_addr_t addr;
    word_t      wr_data;
    logic       ack;        // one cycle, rd_data valid here
    word_t      rd_data;

    modport regs (output sel, wr, addr, wr_data, input ack, rd_data);
    modport arb  (input sel, wr, addr, wr_data, output ack, rd_data);

endinterface

`default_nettype wire

/* bus_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_regs (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_sel_i,
    input  wire logic               bus_rd_nwr_i,
    input  wire logic [3:0]         bus_reg_num_i,
    input  wire logic               bus_bytesel_i,
    input  wire logic [7:0]         bus_data_i,
    input  wire xvid_pkg::intr_t    int_status_i,
    output logic      [7:0]         bus_data_o,
    vram_bus_if.regs                vram,
    output logic                    pal_wr_o,
    output xvid_pkg::color_t        pal_addr_o,
    output xvid_pkg::rgb_t          pal_data_o,
    output xvid_pkg::intr_t         int_mask_o,
    output xvid_pkg::intr_t         int_clear_o,
    output logic      [7:0]         line_cmp_o
);
    import xvid_pkg::*;

    reg_num_t   reg_num;
    logic [7:0] hi_byte;        // even byte waiting for its odd half
    word_t      wr_word;        // full word on odd byte write
    word_t      rd_word;        // readback of addressed register
    word_t      wr_addr;        // full 16 bits kept for readback
    word_t      rd_addr;
    word_t      xr_addr;        // low nibble picks palette entry
    word_t      rd_latch;       // prefetched vram word
    word_t      req_addr;
    logic       wr_even;
    logic       wr_odd;
    logic       rd_strobe;
    logic       rd_data_odd;    // odd byte read of DATA
    logic       req_wr;
    logic       vram_req;       // start a vram access

    assign reg_num     = reg_num_t'(bus_reg_num_i);
    assign wr_word     = {hi_byte, bus_data_i};
    assign wr_even     = bus_sel_i && !bus_rd_nwr_i && !bus_bytesel_i;
    assign wr_odd      = bus_sel_i && !bus_rd_nwr_i && bus_bytesel_i;
    assign rd_strobe   = bus_sel_i && bus_rd_nwr_i;
    assign rd_data_odd = rd_strobe && bus_bytesel_i && (reg_num == REG_DATA);

    assign req_wr   = wr_odd && (reg_num == REG_DATA);
    assign vram_req = req_wr || (wr_odd && reg_num == REG_RD_ADDR) || rd_data_odd;

    always_comb begin
        if (req_wr) begin
            req_addr = wr_addr;
        end else if (reg_num == REG_RD_ADDR) begin
            req_addr = wr_word;             // prefetch from new read address
        end else begin
            req_addr = rd_addr + 1'b1;      // next word after odd DATA read
        end
    end

    always_comb begin
        case (reg_num)
            REG_WR_ADDR:   rd_word = wr_addr;
            REG_RD_ADDR:   rd_word = rd_addr;
            REG_DATA:      rd_word = rd_latch;
            REG_XR_ADDR:   rd_word = xr_addr;
            REG_INT_CTRL:  rd_word = {6'b0, int_mask_o, 6'b0, int_status_i};
            REG_LINE_INTR: rd_word = {8'h00, line_cmp_o};
            default:       rd_word = '0;    // XR_DATA write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_addr     <= '0;
            rd_addr     <= '0;
            xr_addr     <= '0;
            line_cmp_o  <= '0;
            int_mask_o  <= '0;
            int_clear_o <= '0;
            pal_wr_o    <= 1'b0;
            vram.sel    <= 1'b0;
            bus_data_o  <= '0;
        end else begin
            int_clear_o <= '0;                  // strobes last one cycle
            pal_wr_o    <= 1'b0;
            if (vram.ack) begin
                vram.sel <= 1'b0;
            end
            if (wr_even && reg_num == REG_INT_CTRL) begin
                int_mask_o <= bus_data_i[1:0];  // mask takes effect on even byte
            end
            if (wr_odd) begin
                case (reg_num)
                    REG_WR_ADDR:   wr_addr <= wr_word;
                    REG_RD_ADDR:   rd_addr <= wr_word;
                    REG_DATA:      wr_addr <= wr_addr + 1'b1;
                    REG_XR_ADDR:   xr_addr <= wr_word;
                    REG_XR_DATA: begin
                        pal_wr_o     <= 1'b1;
                        xr_addr[3:0] <= xr_addr[3:0] + 1'b1;    // wraps in 16 entries
                    end
                    REG_INT_CTRL:  int_clear_o <= bus_data_i[1:0];  // write 1 to clear
                    REG_LINE_INTR: line_cmp_o <= bus_data_i;
                    default: ;
                endcase
            end
            if (rd_strobe) begin
                bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
            end
            if (rd_data_odd) begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (vram_req) begin
                vram.sel <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_even) begin
            hi_byte <= bus_data_i;
        end
        if (wr_odd && reg_num == REG_XR_DATA) begin
            pal_addr_o <= xr_addr[3:0];
            pal_data_o <= wr_word[11:0];    // top nibble ignored
        end
        if (vram_req) begin
            vram.wr      <= req_wr;
            vram.addr    <= vram_addr_t'(req_addr);
            vram.wr_data <= wr_word;
        end
        if (vram.ack && !vram.wr) begin
            rd_latch <= vram.rd_data;
        end
    end

    // host spacing keeps one access in flight at most
    a_one_req: assert property (@(posedge clk) disable iff (reset_i)
        vram_req |-> !vram.sel);

endmodule

`default_nettype wire

/* vram_arb.sv */
`default_nettype none
`timescale 1ns/1ps

module vram_arb (
    input  wire logic                   clk,
    input  wire logic                   fetch_sel_i,    // video read, always wins
    input  wire xvid_pkg::vram_addr_t   fetch_addr_i,
    output xvid_pkg::word_t             fetch_data_o,
    vram_bus_if.arb                     regs
);
    import xvid_pkg::*;

    word_t mem [VRAM_WORDS];
    word_t rd_q;            // single registered read port
    logic  regs_go;         // register access this cycle

    // ack cycle still has sel high so skip it
    assign regs_go = regs.sel && !fetch_sel_i && !regs.ack;

    always_ff @(posedge clk) begin
        if (regs_go && regs.wr) begin
            mem[regs.addr] <= regs.wr_data;
        end
        rd_q     <= mem[fetch_sel_i ? fetch_addr_i : regs.addr];
        regs.ack <= regs_go;    // data of the access is in rd_q now
    end

    assign fetch_data_o = rd_q;
    assign regs.rd_data = rd_q;

    a_ack_sel: assert property (@(posedge clk) regs.ack |-> regs.sel);

endmodule

`default_nettype wire

/* video_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module video_gen #(
    parameter int H_VISIBLE = 16,   // multiple of 4
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 2,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [7:0]         line_cmp_i,
    input  wire xvid_pkg::word_t    fetch_data_i,
    output logic                    fetch_sel_o,
    output xvid_pkg::vram_addr_t    fetch_addr_o,
    output xvid_pkg::color_t        color_index_o,
    output logic                    dv_de_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output xvid_pkg::intr_t         intr_trigger_o
);
    import xvid_pkg::*;

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);
    localparam int WORDS_PER_LINE = H_VISIBLE / PIX_PER_WORD;

    localparam logic [HW-1:0] H_LAST     = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] H_VIS      = HW'(H_VISIBLE);
    localparam logic [HW-1:0] H_LEAD     = HW'(PIX_PER_WORD);   // fetch one group ahead
    localparam logic [HW-1:0] H_WRAP     = HW'(H_TOTAL - PIX_PER_WORD);
    localparam logic [HW-1:0] H_SYNC_ON  = HW'(H_VISIBLE + H_FRONT);
    localparam logic [HW-1:0] H_SYNC_OFF = HW'(H_VISIBLE + H_FRONT + H_SYNC);
    localparam logic [VW-1:0] V_LAST     = VW'(V_TOTAL - 1);
    localparam logic [VW-1:0] V_VIS      = VW'(V_VISIBLE);
    localparam logic [VW-1:0] V_SYNC_ON  = VW'(V_VISIBLE + V_FRONT);
    localparam logic [VW-1:0] V_SYNC_OFF = VW'(V_VISIBLE + V_FRONT + V_SYNC);

    logic [HW-1:0]              h_cnt;
    logic [VW-1:0]              v_cnt;
    logic [HW-1:0]              f_x;        // position being fetched
    logic [VW-1:0]              f_y;
    logic [VRAM_RD_LATENCY-1:0] fetch_pipe; // msb set when fetch data arrives
    logic [1:0]                 nib;        // pixel within group
    word_t                      next_word;  // fetched, not yet shown
    word_t                      cur_word;   // group on screen
    word_t                      pix_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt <= '0;
            v_cnt <= V_LAST;    // back porch so line 0 gets its first fetch
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_comb begin
        if (h_cnt >= H_WRAP) begin
            f_x = h_cnt - H_WRAP;   // start of next line
            f_y = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            f_x = h_cnt + H_LEAD;
            f_y = v_cnt;
        end
    end

    assign fetch_sel_o  = (f_x < H_VIS) && (f_x[1:0] == 2'b00) && (f_y < V_VIS);
    assign fetch_addr_o = vram_addr_t'(f_y * WORDS_PER_LINE + f_x / PIX_PER_WORD);

    assign nib      = h_cnt[1:0];
    assign pix_word = (nib == 2'd0) ? next_word : cur_word;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_pipe <= '0;
        end else begin
            fetch_pipe <= VRAM_RD_LATENCY'({fetch_pipe, fetch_sel_o});
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_pipe[VRAM_RD_LATENCY-1]) begin
            next_word <= fetch_data_i;
        end
        if (nib == 2'd0) begin
            cur_word <= next_word;
        end
        color_index_o <= pix_word[{~nib, 2'b00} +: 4];  // leftmost pixel in top nibble
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dv_de_o        <= 1'b0;
            hsync_o        <= 1'b0;
            vsync_o        <= 1'b0;
            intr_trigger_o <= '0;
        end else begin
            dv_de_o <= (h_cnt < H_VIS) && (v_cnt < V_VIS);
            hsync_o <= (h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF);
            vsync_o <= (v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF);
            intr_trigger_o[INTR_VBLANK] <= (h_cnt == '0) && (v_cnt == V_VIS);
            intr_trigger_o[INTR_LINE]   <= (h_cnt == '0) && (8'(v_cnt) == line_cmp_i);
        end
    end

    a_cnt_range: assert property (@(posedge clk) disable iff (reset_i)
        (h_cnt <= H_LAST) && (v_cnt <= V_LAST));

endmodule

`default_nettype wire

/* palette_out.sv */
`default_nettype none
`timescale 1ns/1ps

module palette_out (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               pal_wr_i,
    input  wire xvid_pkg::color_t   pal_addr_i,
    input  wire xvid_pkg::rgb_t     pal_data_i,
    input  wire xvid_pkg::color_t   color_index_i,
    input  wire logic               dv_de_i,
    input  wire logic               hsync_i,
    input  wire logic               vsync_i,
    output logic      [3:0]         red_o,
    output logic      [3:0]         green_o,
    output logic      [3:0]         blue_o,
    output logic                    dv_de_o,
    output logic                    hsync_o,
    output logic                    vsync_o
);
    import xvid_pkg::*;

    rgb_t pal_mem [16];
    rgb_t rgb_1;            // lookup stage
    logic de_1;
    logic hsync_1;
    logic vsync_1;

    initial begin
        for (int i = 0; i < 16; i++) begin
            pal_mem[i] = '0;    // black until loaded
        end
    end

    always_ff @(posedge clk) begin
        if (pal_wr_i) begin
            pal_mem[pal_addr_i] <= pal_data_i;
        end
        rgb_1 <= pal_mem[color_index_i];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            {de_1, hsync_1, vsync_1}       <= '0;
            {dv_de_o, hsync_o, vsync_o}    <= '0;
            {red_o, green_o, blue_o}       <= '0;
        end else begin
            {de_1, hsync_1, vsync_1}       <= {dv_de_i, hsync_i, vsync_i};
            {dv_de_o, hsync_o, vsync_o}    <= {de_1, hsync_1, vsync_1};
            {red_o, green_o, blue_o}       <= de_1 ? rgb_1 : '0;   // black in blanking
        end
    end

endmodule

`default_nettype wire

/* intr_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module intr_ctrl (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xvid_pkg::intr_t    intr_trigger_i,     // one cycle per event
    input  wire xvid_pkg::intr_t    int_mask_i,
    input  wire xvid_pkg::intr_t    int_clear_i,        // write 1 to clear
    output xvid_pkg::intr_t         int_status_o,
    output logic                    bus_intr_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            int_status_o <= '0;
            bus_intr_o   <= 1'b0;
        end else begin
            // only new events for enabled sources reach the cpu
            bus_intr_o   <= |(intr_trigger_i & int_mask_i & ~int_status_o);
            int_status_o <= (int_status_o | intr_trigger_i) & ~int_clear_i;  // masked too
        end
    end

    // pending status holds off a repeat until cleared
    a_pulse: assert property (@(posedge clk) disable iff (reset_i)
        bus_intr_o |=> !bus_intr_o);

endmodule

`default_nettype wire

/* xvid_top.sv */
`default_nettype none
`timescale 1ns/1ps

module xvid_top #(
    parameter int H_VISIBLE = 16,
    parameter int H_FRONT   = 2,
    parameter int H_SYNC    = 4,
    parameter int H_BACK    = 2,
    parameter int V_VISIBLE = 8,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 1
) (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_sel_i,          // one cycle access strobe
    input  wire logic           bus_rd_nwr_i,       // 1 = read
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,      // 1 = odd byte
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);
    import xvid_pkg::*;

    logic       fetch_sel;      // video word fetch
    vram_addr_t fetch_addr;
    word_t      fetch_data;

    logic       pal_wr;         // palette write strobe
    color_t     pal_addr;
    rgb_t       pal_data;

    intr_t      int_mask;
    intr_t      int_clear;
    intr_t      int_status;
    intr_t      intr_trigger;
    logic [7:0] line_cmp;

    color_t     color_index;    // video_gen to palette
    logic       vg_de;
    logic       vg_hsync;
    logic       vg_vsync;

    vram_bus_if vram_bus();     // register vram access

    bus_regs bus_regs (
        .clk(clk),
        .reset_i(reset_i),
        .bus_sel_i(bus_sel_i),
        .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i),
        .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i),
        .int_status_i(int_status),
        .bus_data_o(bus_data_o),
        .vram(vram_bus.regs),
        .pal_wr_o(pal_wr),
        .pal_addr_o(pal_addr),
        .pal_data_o(pal_data),
        .int_mask_o(int_mask),
        .int_clear_o(int_clear),
        .line_cmp_o(line_cmp)
    );

    vram_arb vram_arb (
        .clk(clk),
        .fetch_sel_i(fetch_sel),
        .fetch_addr_i(fetch_addr),
        .fetch_data_o(fetch_data),
        .regs(vram_bus.arb)
    );

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) video_gen (
        .clk(clk),
        .reset_i(reset_i),
        .line_cmp_i(line_cmp),
        .fetch_data_i(fetch_data),
        .fetch_sel_o(fetch_sel),
        .fetch_addr_o(fetch_addr),
        .color_index_o(color_index),
        .dv_de_o(vg_de),
        .hsync_o(vg_hsync),
        .vsync_o(vg_vsync),
        .intr_trigger_o(intr_trigger)
    );

    palette_out palette_out (
        .clk(clk),
        .reset_i(reset_i),
        .pal_wr_i(pal_wr),
        .pal_addr_i(pal_addr),
        .pal_data_i(pal_data),
        .color_index_i(color_index),
        .dv_de_i(vg_de),
        .hsync_i(vg_hsync),
        .vsync_i(vg_vsync),
        .red_o(red_o),
        .green_o(green_o),
        .blue_o(blue_o),
        .dv_de_o(dv_de_o),
        .hsync_o(hsync_o),
        .vsync_o(vsync_o)
    );

    intr_ctrl intr_ctrl (
        .clk(clk),
        .reset_i(reset_i),
        .intr_trigger_i(intr_trigger),
        .int_mask_i(int_mask),
        .int_clear_i(int_clear),
        .int_status_o(int_status),
        .bus_intr_o(bus_intr_o)
    );

endmodule

`default_nettype wire

/* tb_xvid_tasks.svh */
`ifndef TB_XVID_TASKS_SVH
`define TB_XVID_TASKS_SVH

// compare two values, count and print a mismatch
task automatic check(input logic [31:0] got, input logic [31:0] expected, input string msg);
    if (got !== expected) begin
        errors++;
        $display("error at %0t ns: %s, got %0h expected %0h", $time, msg, got, expected);
    end
endtask

// single cycle strobe, then the host spacing
task automatic bus_write(input logic [3:0] num, input logic odd, input logic [7:0] data);
    @(posedge clk);
    bus_sel_i     <= 1'b1;
    bus_rd_nwr_i  <= 1'b0;
    bus_reg_num_i <= num;
    bus_bytesel_i <= odd;
    bus_data_i    <= data;
    @(posedge clk);
    bus_sel_i <= 1'b0;
    repeat (BUS_IDLE) @(posedge clk);
endtask

task automatic bus_read(input logic [3:0] num, input logic odd, output logic [7:0] data);
    @(posedge clk);
    bus_sel_i     <= 1'b1;
    bus_rd_nwr_i  <= 1'b1;
    bus_reg_num_i <= num;
    bus_bytesel_i <= odd;
    @(posedge clk);
    bus_sel_i <= 1'b0;
    repeat (BUS_IDLE) @(posedge clk);
    @(negedge clk);
    data = bus_data_o;      // held until the next strobe
endtask

// even byte first, the odd byte commits
task automatic write_word(input logic [3:0] num, input word_t w);
    bus_write(num, 1'b0, w[15:8]);
    bus_write(num, 1'b1, w[7:0]);
endtask

task automatic read_word(input logic [3:0] num, output word_t w);
    logic [7:0] hi;
    logic [7:0] lo;
    bus_read(num, 1'b0, hi);
    bus_read(num, 1'b1, lo);    // odd read of DATA steps the read address
    w = {hi, lo};
endtask

`endif

/* tb_xvid.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_xvid;
    import xvid_pkg::*;

    localparam int H_VIS = 16;
    localparam int H_FP = 2;
    localparam int H_SW = 4;
    localparam int H_BP = 2;
    localparam int V_VIS = 8;
    localparam int V_FP = 1;
    localparam int V_SW = 2;
    localparam int V_BP = 1;
    localparam int V_TOTAL = V_VIS + V_FP + V_SW + V_BP;
    localparam int FRAME_CYC = (H_VIS + H_FP + H_SW + H_BP) * V_TOTAL;   // 288
    localparam int BUS_IDLE = 8;
    localparam int RT_WORDS = 8;
    localparam int IMG_WORDS = H_VIS * V_VIS / PIX_PER_WORD;
    localparam int N_TESTS = 6;
    localparam int SEED = 58631;
    // 4 frames per test plus bus traffic, about 256 accesses of 10 cycles
    localparam int WATCHDOG_NS = N_TESTS * 4 * FRAME_CYC * 40 + 256 * 10 * 40;

    logic       clk;
    logic       reset_i;
    logic       bus_sel_i;
    logic       bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic       bus_intr_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    word_t vram_m [VRAM_WORDS];     // model vram
    rgb_t  pal_m [16];              // model palette
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    bit    pic_on = 0;              // compare pixels this frame

    // frame tracker state, written only by the tracker
    event  frame_start;             // vsync_o rise
    bit    de_q = 0;
    bit    hs_q = 0;
    bit    vs_q = 0;
    int    cyc = 0;
    int    vs_last = 0;
    int    line_idx = 0;
    int    px_idx = 0;
    int    runs = 0;
    int    run_bad = 0;
    int    hs_len = 0;
    int    hs_runs = 0;
    int    hs_bad = 0;
    int    pulses = 0;
    int    pulse_runs = -1;         // lines finished when the last pulse came
    bit    pulse_de = 0;
    int    pix_checked = 0;
    int    frame_cyc = 0;
    int    frame_runs = 0;
    int    frame_run_bad = 0;
    int    frame_hs = 0;
    int    frame_hs_bad = 0;

    `include "tb_xvid_tasks.svh"

    xvid_top #(
        .H_VISIBLE(H_VIS), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_VISIBLE(V_VIS), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP)
    ) dut0 (
        .clk(clk), .reset_i(reset_i),
        .bus_sel_i(bus_sel_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o), .bus_intr_o(bus_intr_o),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // pixel (x, y) from word y*H/4 + x/4, leftmost pixel in the top nibble
    function automatic rgb_t expected_rgb(input int line, input int px);
        word_t  w;
        color_t nib;
        w = vram_m[vram_addr_t'(line * (H_VIS / PIX_PER_WORD) + px / PIX_PER_WORD)];
        nib = w[15 - 4 * (px % PIX_PER_WORD) -: 4];
        return pal_m[nib];
    endfunction

    // frame tracker on the falling edge
    always @(negedge clk) begin
        cyc++;
        if (dv_de_o) begin
            if (pic_on) begin
                check(32'({red_o, green_o, blue_o}), 32'(expected_rgb(line_idx, px_idx)),
                      "pixel colour");
                pix_checked++;
            end
            px_idx++;
        end else begin
            if (pic_on) check(32'({red_o, green_o, blue_o}), 0, "rgb outside display enable");
            if (de_q) begin                 // end of a visible line
                if (px_idx != H_VIS) run_bad++;
                runs++;
                line_idx++;
                px_idx = 0;
            end
        end
        if (hsync_o) begin
            hs_len++;
        end else if (hs_q) begin
            if (hs_len != H_SW) hs_bad++;
            hs_runs++;
            hs_len = 0;
        end
        if (bus_intr_o) begin
            pulses++;
            pulse_runs = runs;
            pulse_de = dv_de_o;
        end
        if (vsync_o && !vs_q) begin         // frame boundary, snapshot then restart
            frame_cyc = cyc - vs_last;
            vs_last = cyc;
            frame_runs = runs;
            frame_run_bad = run_bad;
            frame_hs = hs_runs;
            frame_hs_bad = hs_bad;
            {runs, run_bad, hs_runs, hs_bad} = '0;
            line_idx = 0;
            px_idx = 0;
            -> frame_start;
        end
        de_q = dv_de_o;
        hs_q = hsync_o;
        vs_q = vsync_o;
    end

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%-18s ok", name);
        end else begin
            tests_failed++;
            $display("%-18s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic vram_round_trip();
        int    start;
        word_t got;
        start = int'($urandom % VRAM_WORDS);
        write_word(REG_WR_ADDR, word_t'(start));
        for (int i = 0; i < RT_WORDS; i++) begin
            vram_m[vram_addr_t'(start + i)] = word_t'($urandom);
            write_word(REG_DATA, vram_m[vram_addr_t'(start + i)]);
        end
        write_word(REG_RD_ADDR, word_t'(start));   // prefetch from start
        for (int i = 0; i < RT_WORDS; i++) begin
            read_word(REG_DATA, got);
            check(32'(got), 32'(vram_m[vram_addr_t'(start + i)]), "vram readback");
        end
    endtask

    task automatic register_readback();
        word_t      v;
        word_t      got;
        logic [7:0] b;
        logic [7:0] rb;
        v = word_t'($urandom);
        write_word(REG_WR_ADDR, v);
        read_word(REG_WR_ADDR, got);
        check(32'(got), 32'(v), "WR_ADDR readback");
        v = word_t'($urandom);
        write_word(REG_XR_ADDR, v);
        read_word(REG_XR_ADDR, got);
        check(32'(got), 32'(v), "XR_ADDR readback");
        b = 8'($urandom);
        bus_write(REG_LINE_INTR, 1'b1, b);
        read_word(REG_LINE_INTR, got);
        check(32'(got), 32'(b), "LINE_INTR readback");
        b = 8'(1 + $urandom % 3);                  // nonzero, differs from reset mask
        bus_write(REG_INT_CTRL, 1'b0, b);
        bus_read(REG_INT_CTRL, 1'b0, rb);
        check(32'(rb), 32'(b), "interrupt mask readback");
        bus_write(REG_INT_CTRL, 1'b0, 8'h00);
    endtask

    task automatic picture_frame();
        int seen;
        write_word(REG_XR_ADDR, 16'h0000);
        for (int i = 0; i < 16; i++) begin
            pal_m[color_t'(i)] = rgb_t'($urandom);
            write_word(REG_XR_DATA, {4'($urandom), pal_m[color_t'(i)]});  // top nibble dropped
        end
        write_word(REG_WR_ADDR, 16'h0000);
        for (int i = 0; i < IMG_WORDS; i++) begin
            vram_m[vram_addr_t'(i)] = word_t'($urandom);
            write_word(REG_DATA, vram_m[vram_addr_t'(i)]);
        end
        @(frame_start);
        seen = pix_checked;
        pic_on = 1'b1;
        @(frame_start);
        pic_on = 1'b0;
        check(pix_checked - seen, H_VIS * V_VIS, "pixels seen in one frame");
    endtask

    task automatic sync_counts();
        @(frame_start);
        @(frame_start);             // second snapshot covers a whole frame
        check(frame_runs, V_VIS, "display enable lines per frame");
        check(frame_run_bad, 0, "display enable line length");
        check(frame_cyc, FRAME_CYC, "vsync period");
        check(frame_hs, V_TOTAL, "hsync pulses per frame");
        check(frame_hs_bad, 0, "hsync pulse length");
    endtask

    task automatic vblank_interrupt();
        int         base;
        logic [7:0] st;
        bus_write(REG_LINE_INTR, 1'b1, 8'hff);     // no line ever matches
        bus_write(REG_INT_CTRL, 1'b0, 8'h01);
        @(frame_start);
        bus_write(REG_INT_CTRL, 1'b1, 8'h03);      // clear both sources
        base = pulses;
        @(frame_start);
        check(pulses - base, 1, "vblank pulse count");
        check(pulse_runs, V_VIS, "vblank pulse after last visible line");
        check(32'(pulse_de), 0, "vblank pulse during display enable");
        bus_read(REG_INT_CTRL, 1'b1, st);
        check(32'(st), 1, "vblank status set");
        bus_write(REG_INT_CTRL, 1'b1, 8'h01);
        bus_read(REG_INT_CTRL, 1'b1, st);
        check(32'(st), 0, "vblank status cleared");
        bus_write(REG_INT_CTRL, 1'b0, 8'h00);      // mask off
        base = pulses;
        @(frame_start);
        check(pulses - base, 0, "pulse while masked");
        bus_read(REG_INT_CTRL, 1'b1, st);
        check(32'(st), 1, "status sets while masked");
    endtask

    task automatic line_interrupt();
        int base;
        int n;
        n = 1 + int'($urandom % (V_VIS - 1));     // visible line 1 to 7
        bus_write(REG_LINE_INTR, 1'b1, 8'(n));
        bus_write(REG_INT_CTRL, 1'b0, 8'h02);
        @(frame_start);
        bus_write(REG_INT_CTRL, 1'b1, 8'h03);
        base = pulses;
        @(frame_start);
        check(pulses - base, 1, "line pulse count");
        check(pulse_runs, n, "line pulse after line n-1");
        check(32'(pulse_de), 0, "line pulse during display enable");
        base = pulses;
        @(frame_start);
        check(pulses - base, 0, "second line pulse while pending");
        bus_write(REG_INT_CTRL, 1'b1, 8'h02);
        base = pulses;
        @(frame_start);
        check(pulses - base, 1, "line pulse after clear");
        bus_write(REG_INT_CTRL, 1'b0, 8'h00);
    endtask

    initial begin
        int e;
        reset_i       = 1'b1;
        bus_sel_i     = 1'b0;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = 4'h0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = 8'h00;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        repeat (2) @(posedge clk);
        e = errors;
        vram_round_trip();
        finish_test("vram round trip", e);
        e = errors;
        register_readback();
        finish_test("register readback", e);
        e = errors;
        picture_frame();
        finish_test("picture", e);
        e = errors;
        sync_counts();
        finish_test("sync counts", e);
        e = errors;
        vblank_interrupt();
        finish_test("vblank interrupt", e);
        e = errors;
        line_interrupt();
        finish_test("line interrupt", e);
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* xvid.f */
+incdir+.
xvid_pkg.sv
vram_bus_if.sv
bus_regs.sv
vram_arb.sv
video_gen.sv
palette_out.sv
intr_ctrl.sv
xvid_top.sv
tb_xvid.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
TOP        := tb_xvid
FILELIST   := xvid.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := === PASS ===
FAIL_MSG   := === FAIL ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
